// ==== build.f ====
source/core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/regfile.sv
source/core_top.sv
tb/core_asserts.sv
tb/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= core_tb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000
FILE_LIST ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

  localparam int prog_words = 256;
  localparam int seg_words = 64;
  localparam int num_segs = 4;
  localparam logic [31:0] prog_end = 32'd1024;
  localparam int cycles_per_commit = 20;

  logic                      clock;
  logic                      reset;
  logic                      if_rw_ready = 1'b0;
  logic [core_pkg::xlen-1:0] if_r_data = '0;
  logic [1:0]                if_rw_resp = 2'b00;
  logic                      if_rw_valid;
  logic [core_pkg::xlen-1:0] if_rw_addr;
  logic [1:0]                if_rw_size;
  core_pkg::commit_t         commit;

  integer      seed;
  logic [31:0] prog [prog_words];
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  int          seg_errors [num_segs];
  string       seg_names [num_segs];
  int          n_expected = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cur_seg = 0;
  int          wait_cnt = 0;
  logic        done = 1'b0;

  core_top UUT (
    .clock       (clock),
    .reset       (reset),
    .if_rw_ready (if_rw_ready),
    .if_r_data   (if_r_data),
    .if_rw_resp  (if_rw_resp),
    .if_rw_valid (if_rw_valid),
    .if_rw_addr  (if_rw_addr),
    .if_rw_size  (if_rw_size),
    .commit      (commit)
  );

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [4:0] rand_reg(int lo, int hi);
    return 5'(lo + rand_below(hi - lo + 1));
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_bne(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, core_pkg::f3_bne, off[4:1], off[11],
            core_pkg::op_branch};
  endfunction

  function automatic logic [31:0] rand_alu(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    int kind;
    kind = rand_below(7);
    case (kind)
      0: return enc_r(7'h00, core_pkg::f3_add_sub, rd, rs1, rs2);
      1: return enc_r(7'h20, core_pkg::f3_add_sub, rd, rs1, rs2);
      2: return enc_r(7'h00, core_pkg::f3_and, rd, rs1, rs2);
      3: return enc_r(7'h00, core_pkg::f3_or, rd, rs1, rs2);
      4: return enc_r(7'h00, core_pkg::f3_xor, rd, rs1, rs2);
      5: return {12'(rand_below(4096)), rs1, core_pkg::f3_add_sub, rd, core_pkg::op_imm};
      default: return {20'(rand_below(1 << 20)), rd, core_pkg::op_lui};
    endcase
  endfunction

  // one block of 64 words per test
  task automatic gen_program();
    logic [4:0] prev_rd;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    prev_rd = 5'd1;
    for (int i = 0; i < prog_words; i++) begin
      rd = rand_reg(1, 15);
      rs1 = rand_reg(1, 15);
      rs2 = rand_reg(1, 15);
      case (i / seg_words)
        0: prog[i] = rand_alu(rd, rs1, rs2);
        1: begin
          // each reads the result just before it
          rd = rand_reg(1, 7);
          rs2 = (rand_below(2) == 0) ? prev_rd : rand_reg(1, 7);
          prog[i] = rand_alu(rd, prev_rd, rs2);
          prev_rd = rd;
        end
        2: begin
          rs1 = rand_reg(0, 3);
          rs2 = (rand_below(3) == 0) ? rs1 : rand_reg(0, 3);
          if (rand_below(3) == 0) begin
            prog[i] = enc_bne(rs1, rs2, 13'(8 + 4 * rand_below(7)));
          end else begin
            prog[i] = rand_alu(rand_reg(1, 3), rs1, rs2);
          end
        end
        default: begin
          rd = (rand_below(2) == 0) ? 5'd0 : rand_reg(1, 3);
          rs1 = (rand_below(2) == 0) ? 5'd0 : rand_reg(1, 3);
          rs2 = (rand_below(2) == 0) ? 5'd0 : rand_reg(1, 3);
          prog[i] = rand_alu(rd, rs1, rs2);
        end
      endcase
    end
  endtask

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    if (addr < prog_end) begin
      return prog[addr[9:2]];
    end
    return core_pkg::nop_inst;
  endfunction

  task automatic model_reset();
    m_pc = core_pkg::pc_start;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
  endtask

  // architectural step of the reduced rv32i subset
  task automatic model_step(output core_pkg::commit_t exp);
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] next_pc;
    logic        writes;
    inst = fetch_word(m_pc);
    a = m_regs[inst[19:15]];
    b = m_regs[inst[24:20]];
    val = '0;
    writes = 1'b0;
    next_pc = m_pc + 32'd4;
    case (inst[6:0])
      core_pkg::op_reg: begin
        writes = 1'b1;
        case ({inst[31:25], inst[14:12]})
          {7'h00, 3'b000}: val = a + b;
          {7'h20, 3'b000}: val = a - b;
          {7'h00, 3'b111}: val = a & b;
          {7'h00, 3'b110}: val = a | b;
          {7'h00, 3'b100}: val = a ^ b;
          default: writes = 1'b0;
        endcase
      end
      core_pkg::op_imm: begin
        writes = (inst[14:12] == 3'b000);
        val = a + {{20{inst[31]}}, inst[31:20]};
      end
      core_pkg::op_lui: begin
        writes = 1'b1;
        val = {inst[31:12], 12'h000};
      end
      core_pkg::op_branch: begin
        if (inst[14:12] == 3'b001 && a != b) begin
          next_pc = m_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    exp.valid = 1'b1;
    exp.pc = m_pc;
    exp.inst = inst;
    exp.wen = writes && (inst[11:7] != 5'd0);
    exp.wdest = inst[11:7];
    exp.wdata = val;
    if (exp.wen) begin
      m_regs[inst[11:7]] = val;
    end
    m_pc = next_pc;
  endtask

  task automatic count_commits();
    core_pkg::commit_t scratch;
    model_reset();
    while (m_pc < prog_end) begin
      model_step(scratch);
      n_expected++;
    end
    model_reset();
  endtask

  task automatic report_tests(int upto);
    while (cur_seg < upto) begin
      $display("test %s: %s, %0d mismatches", seg_names[cur_seg],
               (seg_errors[cur_seg] == 0) ? "pass" : "fail", seg_errors[cur_seg]);
      cur_seg++;
    end
  endtask

  task automatic check_commit(core_pkg::commit_t got);
    core_pkg::commit_t exp;
    int seg;
    model_step(exp);
    seg = int'(exp.pc[9:8]);
    report_tests(seg);
    n_checks++;
    // destination and data only matter when a write retires
    if (got.pc !== exp.pc || got.inst !== exp.inst || got.wen !== exp.wen ||
        (exp.wen && (got.wdest !== exp.wdest || got.wdata !== exp.wdata))) begin
      $display("Mismatch at %0t: commit pc %h inst %h wen %b x%0d=%h, expected %h %h %b x%0d=%h",
               $time, got.pc, got.inst, got.wen, got.wdest, got.wdata,
               exp.pc, exp.inst, exp.wen, exp.wdest, exp.wdata);
      n_errors++;
      seg_errors[seg]++;
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // fetch memory raises ready after 0 to 3 idle cycles
  always @(posedge clock) begin
    if (reset) begin
      if_rw_ready <= 1'b0;
      wait_cnt <= rand_below(4);
    end else if (if_rw_valid && if_rw_ready) begin
      if_rw_ready <= 1'b0;
      wait_cnt <= rand_below(4);
    end else if (if_rw_valid) begin
      if (wait_cnt == 0) begin
        if_rw_ready <= 1'b1;
        if_r_data <= fetch_word(if_rw_addr);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  always @(posedge clock) begin
    if (!reset && commit.valid && !done) begin
      check_commit(commit);
      if (m_pc >= prog_end) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    wait (n_expected > 0);
    repeat (n_expected * cycles_per_commit + 10) @(posedge clock);
    if (!done) begin
      $display("timeout: commits stopped after %0d of %0d instructions", n_checks, n_expected);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    seed = 32'h15864806;
    seg_names[0] = "alu_random";
    seg_names[1] = "dependency_chains";
    seg_names[2] = "branches";
    seg_names[3] = "x0_handling";
    gen_program();
    count_commits();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    wait (done);
    report_tests(num_segs);
    $display("test fetch_protocol: %s, %0d assertion failures",
             (UUT.protocol_checks.fail_count == 0) ? "pass" : "fail",
             UUT.protocol_checks.fail_count);
    $display("test completion: pass, %0d of %0d instructions committed", n_checks, n_expected);
    $display("checks %0d, mismatches %0d, assertion failures %0d", n_checks, n_errors,
             UUT.protocol_checks.fail_count);
    if (n_errors == 0 && UUT.protocol_checks.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/core_asserts.sv ====
`timescale 1ns/1ps

module core_asserts (
  input logic                      clock,
  input logic                      reset,
  input logic                      if_rw_valid,
  input logic                      if_rw_ready,
  input logic [core_pkg::xlen-1:0] if_rw_addr,
  input logic [1:0]                if_rw_size,
  input core_pkg::commit_t         commit
);

  int   fail_count = 0;
  logic req_seen;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_seen <= 1'b0;
    end else if (if_rw_valid) begin
      req_seen <= 1'b1;
    end
  end

  // a waiting request keeps valid and address
  hold_request: assert property (
    @(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr)
  ) else begin
    fail_count++;
    $error("fetch request dropped or changed address before ready");
  end

  first_request: assert property (
    @(posedge clock) disable iff (reset)
    if_rw_valid && !req_seen |-> if_rw_addr == core_pkg::pc_start
  ) else begin
    fail_count++;
    $error("first fetch request is not at the reset pc");
  end

  // word transfers only
  word_size: assert property (
    @(posedge clock) disable iff (reset)
    if_rw_valid |-> if_rw_size == 2'b10
  ) else begin
    fail_count++;
    $error("fetch request size is not a word");
  end

  quiet_in_reset: assert property (
    @(posedge clock) reset && $past(reset) |-> !commit.valid
  ) else begin
    fail_count++;
    $error("commit valid raised during reset");
  end

endmodule

bind core_top core_asserts protocol_checks (.*);

// ==== source/core_top.sv ====
`timescale 1ns/1ps

module core_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      if_rw_ready,
  input  logic [core_pkg::xlen-1:0] if_r_data,
  input  logic [1:0]                if_rw_resp,
  output logic                      if_rw_valid,
  output logic [core_pkg::xlen-1:0] if_rw_addr,
  output logic [1:0]                if_rw_size,
  output core_pkg::commit_t         commit
);

  // stage handshakes
  logic                if_to_id_valid;
  logic                id_to_ex_valid;
  logic                ex_to_wb_valid;
  logic                id_allowin;
  logic                ex_allowin;
  core_pkg::if_to_id_t if_to_id_bus;
  core_pkg::id_to_ex_t id_to_ex_bus;
  core_pkg::ex_to_wb_t ex_to_wb_bus;

  core_pkg::redirect_t  redirect;
  core_pkg::reg_write_t ex_write;
  core_pkg::reg_write_t reg_write;

  // decode to register file
  logic [core_pkg::reg_addr_w-1:0] rs1_addr;
  logic [core_pkg::reg_addr_w-1:0] rs2_addr;
  logic [core_pkg::xlen-1:0]       r_data1;
  logic [core_pkg::xlen-1:0]       r_data2;

  fetch_stage fetch (
    .clock          (clock),
    .reset          (reset),
    .id_allowin     (id_allowin),
    .redirect       (redirect),
    .if_rw_ready    (if_rw_ready),
    .if_r_data      (if_r_data),
    .if_rw_resp     (if_rw_resp),
    .if_rw_valid    (if_rw_valid),
    .if_rw_addr     (if_rw_addr),
    .if_rw_size     (if_rw_size),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_bus   (if_to_id_bus)
  );

  decode_stage decode (
    .clock          (clock),
    .reset          (reset),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_bus   (if_to_id_bus),
    .ex_allowin     (ex_allowin),
    .redirect       (redirect),
    .r_data1        (r_data1),
    .r_data2        (r_data2),
    .ex_write       (ex_write),
    .wb_write       (reg_write),
    .id_allowin     (id_allowin),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .id_to_ex_valid (id_to_ex_valid),
    .id_to_ex_bus   (id_to_ex_bus)
  );

  execute_stage execute (
    .clock          (clock),
    .reset          (reset),
    .id_to_ex_valid (id_to_ex_valid),
    .id_to_ex_bus   (id_to_ex_bus),
    .ex_allowin     (ex_allowin),
    .ex_write       (ex_write),
    .redirect       (redirect),
    .ex_to_wb_valid (ex_to_wb_valid),
    .ex_to_wb_bus   (ex_to_wb_bus)
  );

  // writeback never back-pressures execute
  writeback_stage writeback (
    .clock          (clock),
    .reset          (reset),
    .ex_to_wb_valid (ex_to_wb_valid),
    .ex_to_wb_bus   (ex_to_wb_bus),
    .wb_allowin     (),
    .reg_write      (reg_write),
    .commit         (commit)
  );

  regfile gprs (
    .clock          (clock),
    .reset          (reset),
    .reg_write      (reg_write),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .r_data1        (r_data1),
    .r_data2        (r_data2)
  );

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic                            clock,
  input  logic                            reset,
  input  core_pkg::reg_write_t            reg_write,
  input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [core_pkg::xlen-1:0]       r_data1,
  output logic [core_pkg::xlen-1:0]       r_data2
);

  logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_addr_w];

  // x0 reads zero, same-cycle write goes straight through
  function automatic logic [core_pkg::xlen-1:0] read_port(
    input logic [core_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (reg_write.ena && reg_write.addr == addr) begin
      return reg_write.data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**core_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write.ena && reg_write.addr != '0) begin
      regs[reg_write.addr] <= reg_write.data;
    end
  end

  assign r_data1 = read_port(rs1_addr);
  assign r_data2 = read_port(rs2_addr);

endmodule

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ex_to_wb_valid,
  input  core_pkg::ex_to_wb_t  ex_to_wb_bus,
  output logic                 wb_allowin,
  output core_pkg::reg_write_t reg_write,
  output core_pkg::commit_t    commit
);

  logic                wb_valid;
  core_pkg::ex_to_wb_t wb_buf;
  logic                wb_wen;

  // retires one instruction per cycle, never stalls
  assign wb_allowin = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= ex_to_wb_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_to_wb_valid && wb_allowin) begin
      wb_buf <= ex_to_wb_bus;
    end
  end

  // x0 target never writes
  assign wb_wen = wb_valid && wb_buf.wen && (wb_buf.wdest != '0);

  always_comb begin
    reg_write.ena = wb_wen;
    reg_write.addr = wb_buf.wdest;
    reg_write.data = wb_buf.wdata;
    commit.valid = wb_valid;
    commit.pc = wb_buf.pc;
    commit.inst = wb_buf.inst;
    commit.wen = wb_wen;
    commit.wdest = wb_wen ? wb_buf.wdest : '0;
    commit.wdata = wb_wen ? wb_buf.wdata : '0;
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 id_to_ex_valid,
  input  core_pkg::id_to_ex_t  id_to_ex_bus,
  output logic                 ex_allowin,
  output core_pkg::reg_write_t ex_write,
  output core_pkg::redirect_t  redirect,
  output logic                 ex_to_wb_valid,
  output core_pkg::ex_to_wb_t  ex_to_wb_bus
);

  logic                      ex_valid;
  core_pkg::id_to_ex_t       ex_buf;
  logic [core_pkg::xlen-1:0] alu_result;

  // writeback always takes the one-cycle result
  assign ex_allowin = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      // the issuing instruction is younger than a taken branch
      ex_valid <= id_to_ex_valid && !redirect.taken;
    end
  end

  always_ff @(posedge clock) begin
    if (id_to_ex_valid) begin
      ex_buf <= id_to_ex_bus;
    end
  end

  always_comb begin
    case (ex_buf.alu_op)
      core_pkg::alu_add: alu_result = ex_buf.opnd_a + ex_buf.opnd_b;
      core_pkg::alu_sub: alu_result = ex_buf.opnd_a - ex_buf.opnd_b;
      core_pkg::alu_and: alu_result = ex_buf.opnd_a & ex_buf.opnd_b;
      core_pkg::alu_or: alu_result = ex_buf.opnd_a | ex_buf.opnd_b;
      core_pkg::alu_xor: alu_result = ex_buf.opnd_a ^ ex_buf.opnd_b;
      core_pkg::alu_pass_b: alu_result = ex_buf.opnd_b;
      default: alu_result = '0;
    endcase
  end

  // bne resolves as it moves on to writeback
  always_comb begin
    redirect.taken = ex_valid && ex_buf.is_branch &&
                     (ex_buf.opnd_a != ex_buf.rs2_val);
    redirect.target = ex_buf.branch_target;
  end

  always_comb begin
    ex_write.ena = ex_valid && ex_buf.wen;
    ex_write.addr = ex_buf.wdest;
    ex_write.data = alu_result;
  end

  assign ex_to_wb_valid = ex_valid;

  always_comb begin
    ex_to_wb_bus.pc = ex_buf.pc;
    ex_to_wb_bus.inst = ex_buf.inst;
    ex_to_wb_bus.wen = ex_buf.wen;
    ex_to_wb_bus.wdest = ex_buf.wdest;
    ex_to_wb_bus.wdata = alu_result;
  end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            if_to_id_valid,
  input  core_pkg::if_to_id_t             if_to_id_bus,
  input  logic                            ex_allowin,
  input  core_pkg::redirect_t             redirect,
  input  logic [core_pkg::xlen-1:0]       r_data1,
  input  logic [core_pkg::xlen-1:0]       r_data2,
  input  core_pkg::reg_write_t            ex_write,
  input  core_pkg::reg_write_t            wb_write,
  output logic                            id_allowin,
  output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  output logic                            id_to_ex_valid,
  output core_pkg::id_to_ex_t             id_to_ex_bus
);

  logic                      id_valid;
  core_pkg::if_to_id_t       id_buf;
  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic                      f7_ok;
  logic [core_pkg::xlen-1:0] imm_i;
  logic [core_pkg::xlen-1:0] imm_u;
  logic [core_pkg::xlen-1:0] imm_b;
  core_pkg::alu_op_t         alu_op;
  logic                      use_rs1;
  logic                      use_rs2;
  logic                      use_imm_u;
  logic                      wen;
  logic                      is_bne;
  logic                      hazard;

  // pending write to a nonzero source register
  function automatic logic raw_dep(
    input logic [core_pkg::reg_addr_w-1:0] src,
    input core_pkg::reg_write_t            w
  );
    return w.ena && (w.addr == src) && (src != '0);
  endfunction

  assign opcode = id_buf.inst[6:0];
  assign funct3 = id_buf.inst[14:12];
  assign funct7 = id_buf.inst[31:25];
  assign rs1_addr = id_buf.inst[19:15];
  assign rs2_addr = id_buf.inst[24:20];

  assign imm_i = {{20{id_buf.inst[31]}}, id_buf.inst[31:20]};
  assign imm_u = {id_buf.inst[31:12], 12'b0};
  assign imm_b = {{20{id_buf.inst[31]}}, id_buf.inst[7], id_buf.inst[30:25],
                  id_buf.inst[11:8], 1'b0};

  // funct7 is zero except for sub
  assign f7_ok = (funct7 == 7'b0000000) ||
                 (funct7 == 7'b0100000 && funct3 == core_pkg::f3_add_sub);

  always_comb begin
    alu_op = core_pkg::alu_add;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm_u = 1'b0;
    wen = 1'b0;
    is_bne = 1'b0;
    case (opcode)
      core_pkg::op_reg: begin
        if (f7_ok) begin
          wen = 1'b1;
          case (funct3)
            core_pkg::f3_add_sub: alu_op = funct7[5] ? core_pkg::alu_sub : core_pkg::alu_add;
            core_pkg::f3_xor: alu_op = core_pkg::alu_xor;
            core_pkg::f3_or: alu_op = core_pkg::alu_or;
            core_pkg::f3_and: alu_op = core_pkg::alu_and;
            default: wen = 1'b0;
          endcase
          use_rs1 = wen;
          use_rs2 = wen;
        end
      end
      core_pkg::op_imm: begin
        if (funct3 == core_pkg::f3_add_sub) begin
          wen = 1'b1;
          use_rs1 = 1'b1;
        end
      end
      core_pkg::op_lui: begin
        wen = 1'b1;
        use_imm_u = 1'b1;
        alu_op = core_pkg::alu_pass_b;
      end
      core_pkg::op_branch: begin
        if (funct3 == core_pkg::f3_bne) begin
          is_bne = 1'b1;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      // anything else retires as a no-op
      default: ;
    endcase
  end

  assign hazard = (use_rs1 && (raw_dep(rs1_addr, ex_write) || raw_dep(rs1_addr, wb_write))) ||
                  (use_rs2 && (raw_dep(rs2_addr, ex_write) || raw_dep(rs2_addr, wb_write)));

  assign id_to_ex_valid = id_valid && !hazard;
  assign id_allowin = !id_valid || (!hazard && ex_allowin);

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (redirect.taken) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_to_id_valid && id_allowin) begin
      id_buf <= if_to_id_bus;
    end
  end

  always_comb begin
    id_to_ex_bus.pc = id_buf.pc;
    id_to_ex_bus.inst = id_buf.inst;
    id_to_ex_bus.alu_op = alu_op;
    id_to_ex_bus.opnd_a = r_data1;
    id_to_ex_bus.opnd_b = use_rs2 ? r_data2 : (use_imm_u ? imm_u : imm_i);
    id_to_ex_bus.rs2_val = r_data2;
    id_to_ex_bus.is_branch = is_bne;
    id_to_ex_bus.branch_target = id_buf.pc + imm_b;
    id_to_ex_bus.wen = wen;
    id_to_ex_bus.wdest = id_buf.inst[11:7];
  end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      id_allowin,
  input  core_pkg::redirect_t       redirect,
  input  logic                      if_rw_ready,
  input  logic [core_pkg::xlen-1:0] if_r_data,
  // response code is accepted whatever its value
  input  logic [1:0]                if_rw_resp,
  output logic                      if_rw_valid,
  output logic [core_pkg::xlen-1:0] if_rw_addr,
  output logic [1:0]                if_rw_size,
  output logic                      if_to_id_valid,
  output core_pkg::if_to_id_t       if_to_id_bus
);

  logic [core_pkg::xlen-1:0] next_pc;
  logic [core_pkg::xlen-1:0] pc_d;
  logic                      stale;
  logic                      fire;
  logic                      word_in;
  logic                      buf_free;
  logic                      issue;

  assign if_rw_size = core_pkg::size_word;
  assign fire = if_rw_valid && if_rw_ready;

  // a word that raced a taken branch is dropped
  assign word_in = fire && !stale && !redirect.taken;

  // buffer is empty after this cycle and nothing lands in it
  assign buf_free = (!if_to_id_valid || id_allowin || redirect.taken) && !word_in;

  // only one request in flight, and only when its word has a place to go
  assign issue = (!if_rw_valid || fire) && buf_free;

  always_comb begin
    if (redirect.taken) begin
      pc_d = redirect.target;
    end else if (word_in) begin
      pc_d = if_rw_addr + 32'd4;
    end else begin
      pc_d = next_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      next_pc <= core_pkg::pc_start;
      if_rw_valid <= 1'b0;
      stale <= 1'b0;
      if_to_id_valid <= 1'b0;
    end else begin
      next_pc <= pc_d;
      if (issue) begin
        if_rw_valid <= 1'b1;
      end else if (fire) begin
        if_rw_valid <= 1'b0;
      end
      // branch while the request waits for ready
      if (redirect.taken) begin
        stale <= if_rw_valid && !fire;
      end else if (fire) begin
        stale <= 1'b0;
      end
      if (word_in) begin
        if_to_id_valid <= 1'b1;
      end else if (id_allowin || redirect.taken) begin
        if_to_id_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      if_rw_addr <= pc_d;
    end
    if (word_in) begin
      if_to_id_bus.pc <= if_rw_addr;
      if_to_id_bus.inst <= if_r_data;
    end
  end

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

  // widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] pc_start = 32'h0000_0000;

  // fetch transfer size, word only
  localparam logic [1:0] size_word = 2'b10;

  // major opcodes
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // funct3 codes in use
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_bne = 3'b001;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } if_to_id_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    alu_op_t               alu_op;
    logic [xlen-1:0]       opnd_a;
    logic [xlen-1:0]       opnd_b;
    logic [xlen-1:0]       rs2_val;
    logic                  is_branch;
    logic [xlen-1:0]       branch_target;
    logic                  wen;
    logic [reg_addr_w-1:0] wdest;
  } id_to_ex_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    logic                  wen;
    logic [reg_addr_w-1:0] wdest;
    logic [xlen-1:0]       wdata;
  } ex_to_wb_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    logic                  wen;
    logic [reg_addr_w-1:0] wdest;
    logic [xlen-1:0]       wdata;
  } commit_t;

  typedef struct packed {
    logic                  ena;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } reg_write_t;

endpackage
